// ==== dram_bridge.f ====
rtl/dram_pkg.sv
rtl/mem_port.sv
rtl/port_arbiter.sv
rtl/mig_ui_seq.sv
rtl/dram_bridge_top.sv
verif/mig_ui_model.sv
verif/tb_dram_bridge.sv

// ==== verif/tb_dram_bridge.sv ====
`timescale 1ns/1ps

module tb_dram_bridge
  import dram_pkg::*;
();

  localparam int MEM_ADDR_BITS = 27;
  localparam int CLK_PERIOD    = 8;
  localparam int CALIB_CYCLES  = 50;
  localparam int N_TXN         = 80;  // Upper bound on accesses issued below
  localparam int WATCHDOG_NS   = (N_TXN * 200 + CALIB_CYCLES) * CLK_PERIOD;

  logic        app_ui_clk;
  logic        app_ui_rst;
  logic        calib_complete;
  mem_in_type  ifetch_req;
  mem_in_type  data_req;
  mem_out_type ifetch_rsp;
  mem_out_type data_rsp;
  ui_req_type  ui_req;
  ui_rsp_type  ui_rsp;

  integer      seed = 32'hb2a3;
  data64_t     sb [cpu_addr_t];  // Expected memory with one entry per 64-bit word
  logic [1:0]  exp_busy;         // Accepted request outstanding on each port
  logic [1:0]  exp_err;
  logic [1:0]  exp_read;
  data64_t     exp_rdata [2];
  logic        alt_phase;
  logic [1:0]  last_port;        // 2 means no completion yet

  dram_bridge_top #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) UUT (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .calib_complete (calib_complete),
    .ifetch_req     (ifetch_req),
    .ifetch_rsp     (ifetch_rsp),
    .data_req       (data_req),
    .data_rsp       (data_rsp),
    .ui_req         (ui_req),
    .ui_rsp         (ui_rsp)
  );

  mig_ui_model #(.CALIB_CYCLES(CALIB_CYCLES)) u_ui_model (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .ui_req         (ui_req),
    .ui_rsp         (ui_rsp),
    .calib_complete (calib_complete)
  );

  always #(CLK_PERIOD / 2) app_ui_clk = ~app_ui_clk;

  function automatic data64_t sb_word(cpu_addr_t addr);
    cpu_addr_t key;
    key = {addr[31:3], 3'b000};
    return sb.exists(key) ? sb[key] : '0;
  endfunction

  function automatic data64_t merge_bytes(data64_t old, data64_t nw, strb_t strb);
    data64_t res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = nw[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic mem_out_type port_rsp(bit port);
    return port ? data_rsp : ifetch_rsp;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // Port 0 is ifetch, port 1 is data; returns once the response pulse is gone
  task automatic do_access(input bit port, input cpu_addr_t addr, input data64_t wdata,
                           input strb_t wstrb);
    mem_in_type  rq;
    mem_out_type r;
    logic        in_range;
    rq       = '{mem_valid: 1'b1, mem_addr: addr, mem_wdata: wdata, mem_wstrb: wstrb};
    in_range = addr < (64'd1 << MEM_ADDR_BITS);
    @(posedge app_ui_clk);
    #1;
    if (port) begin
      data_req = rq;
    end else begin
      ifetch_req = rq;
    end
    exp_busy[port]  = in_range;
    exp_err[port]   = !in_range;
    exp_read[port]  = in_range && (wstrb == '0);
    exp_rdata[port] = sb_word(addr);
    if (in_range && wstrb != '0) begin
      sb[{addr[31:3], 3'b000}] = merge_bytes(sb_word(addr), wdata, wstrb);
    end
    @(posedge app_ui_clk);
    #1;
    rq.mem_valid = 1'b0;
    if (port) begin
      data_req = rq;
    end else begin
      ifetch_req = rq;
    end
    r = port_rsp(port);
    while (!(r.mem_ready || r.mem_error)) begin
      @(posedge app_ui_clk);
      #1;
      r = port_rsp(port);
    end
    @(posedge app_ui_clk);  // Edge that samples the pulse
    #1;
    exp_busy[port] = 1'b0;
    exp_err[port]  = 1'b0;
    exp_read[port] = 1'b0;
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  always @(posedge app_ui_clk) begin
    if (!alt_phase) begin
      last_port <= 2'd2;
    end else if (ifetch_rsp.mem_ready) begin
      last_port <= 2'd0;
    end else if (data_rsp.mem_ready) begin
      last_port <= 2'd1;
    end
  end

  a_quiet_before_calib : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    !calib_complete |-> !(ui_req.app_en || ui_req.app_wdf_wren ||
                          ifetch_rsp.mem_ready || data_rsp.mem_ready)
  ) else stop_on_error($sformatf("Error app_en=%h app_wdf_wren=%h mem_ready=%h %h uncalibrated",
                                 $sampled(ui_req.app_en), $sampled(ui_req.app_wdf_wren),
                                 $sampled(ifetch_rsp.mem_ready),
                                 $sampled(data_rsp.mem_ready)));

  // One beat per write burst
  a_wdf_single_beat : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    ui_req.app_wdf_end == ui_req.app_wdf_wren
  ) else stop_on_error($sformatf("Error ui_req.app_wdf_end=%h app_wdf_wren=%h",
                                 $sampled(ui_req.app_wdf_end),
                                 $sampled(ui_req.app_wdf_wren)));

  a_ui_cmd_owned : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    ui_req.app_en && ui_rsp.app_rdy |-> exp_busy != 2'b00
  ) else stop_on_error($sformatf("Error ui_req.app_addr=%h issued with no accepted request",
                                 $sampled(ui_req.app_addr)));

  for (genvar p = 0; p < 2; p++) begin : g_port_chk
    localparam string NAME = (p == 0) ? "ifetch_rsp" : "data_rsp";
    mem_out_type rsp;
    assign rsp = (p == 0) ? ifetch_rsp : data_rsp;

    a_rdata : assert property (
      @(posedge app_ui_clk) disable iff (app_ui_rst)
      rsp.mem_ready && exp_read[p] |-> rsp.mem_rdata == exp_rdata[p]
    ) else stop_on_error($sformatf("Error %s.mem_rdata got %h expected %h",
                                   NAME, $sampled(rsp.mem_rdata), exp_rdata[p]));

    // Strict turns while both ports stream
    a_ready_owned : assert property (
      @(posedge app_ui_clk) disable iff (app_ui_rst)
      rsp.mem_ready |-> exp_busy[p] && !(alt_phase && last_port == p)
    ) else stop_on_error($sformatf("Error %s.mem_ready=%h unexpected or out of turn",
                                   NAME, $sampled(rsp.mem_ready)));

    a_error : assert property (
      @(posedge app_ui_clk) disable iff (app_ui_rst)
      rsp.mem_error |-> exp_err[p] && !rsp.mem_ready
    ) else stop_on_error($sformatf("Error %s.mem_error=%h mem_ready=%h unexpected",
                                   NAME, $sampled(rsp.mem_error), $sampled(rsp.mem_ready)));
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    cpu_addr_t addr;
    strb_t     strb;
    app_ui_clk = 1'b0;
    app_ui_rst = 1'b1;
    ifetch_req = '0;
    data_req   = '0;
    exp_busy   = '0;
    exp_err    = '0;
    exp_read   = '0;
    exp_rdata  = '{default: '0};
    alt_phase  = 1'b0;
    repeat (2) @(posedge app_ui_clk);
    #1;
    app_ui_rst = 1'b0;
    do_access(1, 32'h0000_0100, 64'h0123_4567_89ab_cdef, 8'hff);  // Pending through calibration
    for (int h = 0; h < 2; h++) begin
      addr = 32'h0000_0100 + 8 * h;  // Low then high half of one beat
      do_access(1, addr, 64'hfedc_ba98_7654_3210, 8'hff);
      do_access(1, addr, 64'h5555_aaaa_3333_cccc, 8'h5a);
      do_access(1, addr, '0, 8'h00);
    end
    do_access(1, 32'h0800_0000, 64'hdead_beef_dead_beef, 8'hff);
    do_access(0, 32'hffff_fff8, '0, 8'h00);
    fork
      do_access(0, 32'h0000_0100, '0, 8'h00);
      do_access(1, 32'h0000_0108, '0, 8'h00);
    join
    for (int i = 0; i < 16; i++) begin
      do_access(1, 8 * i, {$random(seed), $random(seed)}, 8'hff);  // Code region for ifetch
    end
    alt_phase = 1'b1;
    fork
      for (int i = 0; i < 24; i++) begin
        do_access(0, 8 * ((5 * i) % 16), '0, 8'h00);
      end
      for (int j = 0; j < 24; j++) begin
        addr = 32'h0000_0200 + 8 * ($random(seed) & 15);
        strb = ($random(seed) & 1) ? strb_t'($random(seed)) : 8'h00;
        do_access(1, addr, {$random(seed), $random(seed)}, strb);
      end
    join
    alt_phase = 1'b0;
    $display("All tests passed!");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    stop_on_error("Timeout, the bridge stopped completing requests");
  end

endmodule

// ==== verif/mig_ui_model.sv ====
`timescale 1ns/1ps

module mig_ui_model
  import dram_pkg::*;
#(
  parameter int CALIB_CYCLES = 50
) (
  input  logic       app_ui_clk,
  input  logic       app_ui_rst,
  input  ui_req_type ui_req,
  output ui_rsp_type ui_rsp,
  output logic       calib_complete
);

  data128_t mem [app_addr_t];  // Sparse beat storage
  integer   seed = 32'hb2a3;
  int       calib_cnt;
  int       rd_wait;
  logic     rd_busy;
  data128_t rd_beat;
  data128_t wdf_data;
  mask_t    wdf_mask;

  // Unwritten beats read as zero
  function automatic data128_t beat_at(app_addr_t addr);
    return mem.exists(addr) ? mem[addr] : '0;
  endfunction

  initial begin
    ui_rsp         = '0;
    calib_complete = 1'b0;
  end

  // Handshakes use the values from before the edge and outputs change 1 ns later
  always @(posedge app_ui_clk) begin : ui_step
    ui_req_type req_s;
    ui_rsp_type rsp_s;
    logic       rst_s;
    data128_t   beat;
    req_s = ui_req;
    rsp_s = ui_rsp;
    rst_s = app_ui_rst;
    #1;
    if (rst_s) begin
      ui_rsp         = '0;
      calib_complete = 1'b0;
      calib_cnt      = 0;
      rd_busy        = 1'b0;
    end else begin
      if (calib_cnt < CALIB_CYCLES) begin
        calib_cnt++;
      end else begin
        calib_complete = 1'b1;
      end
      if (req_s.app_wdf_wren && rsp_s.app_wdf_rdy) begin
        wdf_data = req_s.app_wdf_data;
        wdf_mask = req_s.app_wdf_mask;
      end
      if (req_s.app_en && rsp_s.app_rdy) begin
        beat = beat_at(req_s.app_addr);
        if (req_s.app_cmd == UI_CMD_WR) begin
          for (int i = 0; i < 16; i++) begin
            if (!wdf_mask[i]) begin
              beat[8*i +: 8] = wdf_data[8*i +: 8];  // Unmasked byte takes new data
            end
          end
          mem[req_s.app_addr] = beat;
        end else begin
          rd_beat = beat;
          rd_wait = $random(seed) & 7;  // Extra read latency
          rd_busy = 1'b1;
        end
      end
      ui_rsp.app_rd_data       = '0;
      ui_rsp.app_rd_data_valid = 1'b0;
      ui_rsp.app_rd_data_end   = 1'b0;
      if (rd_busy && rd_wait == 0) begin
        ui_rsp.app_rd_data       = rd_beat;
        ui_rsp.app_rd_data_valid = 1'b1;
        ui_rsp.app_rd_data_end   = 1'b1;
        rd_busy                  = 1'b0;
      end else if (rd_busy) begin
        rd_wait--;
      end
      ui_rsp.app_rdy     = calib_complete && (($random(seed) & 3) != 0);
      ui_rsp.app_wdf_rdy = calib_complete && (($random(seed) & 3) != 0);
    end
  end

endmodule

// ==== rtl/dram_bridge_top.sv ====
`timescale 1ns/1ps

module dram_bridge_top
  import dram_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 27
) (
  input  logic        app_ui_clk,
  input  logic        app_ui_rst,
  input  logic        calib_complete,
  input  mem_in_type  ifetch_req,
  output mem_out_type ifetch_rsp,
  input  mem_in_type  data_req,
  output mem_out_type data_rsp,
  output ui_req_type  ui_req,
  input  ui_rsp_type  ui_rsp
);

  mem_in_type  ifetch_pend;
  mem_in_type  data_pend;
  mem_out_type ifetch_port_rsp;
  mem_out_type data_port_rsp;
  logic        ifetch_done;
  logic        data_done;
  mem_in_type  grant_req;
  mem_out_type seq_rsp;
  data64_t     rsp_rdata;

  // --------------------------------------------------
  // Port front ends
  // --------------------------------------------------
  mem_port #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_ifetch_port (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .cpu_req    (ifetch_req),
    .cpu_rsp    (ifetch_port_rsp),
    .pend_req   (ifetch_pend),
    .done       (ifetch_done)
  );

  mem_port #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_data_port (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .cpu_req    (data_req),
    .cpu_rsp    (data_port_rsp),
    .pend_req   (data_pend),
    .done       (data_done)
  );

  // Arbiter holds the read data for the registered ready pulse
  assign ifetch_rsp = '{mem_ready: ifetch_port_rsp.mem_ready,
                        mem_error: ifetch_port_rsp.mem_error,
                        mem_rdata: rsp_rdata};
  assign data_rsp   = '{mem_ready: data_port_rsp.mem_ready,
                        mem_error: data_port_rsp.mem_error,
                        mem_rdata: rsp_rdata};

  // --------------------------------------------------
  // Arbiter and UI sequencer
  // --------------------------------------------------
  port_arbiter u_arbiter (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .port0_req  (ifetch_pend),
    .port1_req  (data_pend),
    .grant_req  (grant_req),
    .seq_rsp    (seq_rsp),
    .port0_done (ifetch_done),
    .port1_done (data_done),
    .rsp_rdata  (rsp_rdata)
  );

  mig_ui_seq #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_ui_seq (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .req            (grant_req),
    .rsp            (seq_rsp),
    .calib_complete (calib_complete),
    .ui_req         (ui_req),
    .ui_rsp         (ui_rsp)
  );

endmodule

// ==== rtl/mig_ui_seq.sv ====
`timescale 1ns/1ps

module mig_ui_seq
  import dram_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 27
) (
  input  logic        app_ui_clk,
  input  logic        app_ui_rst,
  input  mem_in_type  req,
  output mem_out_type rsp,
  input  logic        calib_complete,
  output ui_req_type  ui_req,
  input  ui_rsp_type  ui_rsp
);

  typedef enum logic [2:0] {
    idle,
    preset,
    send_data,
    set_cmd_wr,
    set_cmd_rd,
    recv_data
  } state_t;

  typedef struct packed {
    cpu_addr_t addr;
    data64_t   wdata;
    strb_t     wstrb;
    app_addr_t app_addr;
    data128_t  wdf_data;
    mask_t     wdf_mask;
  } cap_t;

  state_t state;
  state_t state_nxt;
  cap_t   cap;
  mask_t  mask_nxt;

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------
  always_comb begin
    state_nxt = state;
    unique case (state)
      idle: begin
        if (req.mem_valid && calib_complete) begin
          state_nxt = preset;
        end
      end
      preset: begin
        if (|cap.wstrb) begin
          state_nxt = send_data;
        end else begin
          state_nxt = set_cmd_rd;
        end
      end
      send_data: begin
        if (ui_rsp.app_wdf_rdy) begin
          state_nxt = set_cmd_wr;
        end
      end
      set_cmd_wr: begin
        if (ui_rsp.app_rdy) begin
          state_nxt = idle;
        end
      end
      set_cmd_rd: begin
        if (ui_rsp.app_rdy) begin
          state_nxt = recv_data;
        end
      end
      recv_data: begin
        if (ui_rsp.app_rd_data_valid) begin
          state_nxt = idle;
        end
      end
      default: begin
        state_nxt = idle;
      end
    endcase
  end

  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------------------------------------
  // Request capture and beat preparation
  // --------------------------------------------------
  // Only the addressed half of the beat gets written
  always_comb begin
    mask_nxt = '1;
    if (cap.addr[3]) begin
      mask_nxt[15:8] = ~cap.wstrb;
    end else begin
      mask_nxt[7:0] = ~cap.wstrb;
    end
  end

  always_ff @(posedge app_ui_clk) begin
    if (state == idle && req.mem_valid) begin
      cap.addr  <= req.mem_addr;
      cap.wdata <= req.mem_wdata;
      cap.wstrb <= req.mem_wstrb;
    end
    if (state == preset) begin
      cap.app_addr <= app_addr_t'({cap.addr[MEM_ADDR_BITS-1:4], 4'b0000});  // 16-byte aligned
      cap.wdf_data <= {cap.wdata, cap.wdata};  // Mirror into both halves
      cap.wdf_mask <= mask_nxt;
    end
  end

  // --------------------------------------------------
  // UI outputs
  // --------------------------------------------------
  always_comb begin
    ui_req.app_addr     = cap.app_addr;
    ui_req.app_cmd      = (state == set_cmd_rd) ? UI_CMD_RD : UI_CMD_WR;
    ui_req.app_en       = (state == set_cmd_wr) || (state == set_cmd_rd);
    ui_req.app_wdf_data = cap.wdf_data;
    ui_req.app_wdf_wren = (state == send_data);
    ui_req.app_wdf_end  = (state == send_data);  // Single beat burst
    ui_req.app_wdf_mask = cap.wdf_mask;
  end

  always_comb begin
    rsp = '0;
    if (state == set_cmd_wr && ui_rsp.app_rdy) begin
      rsp.mem_ready = 1'b1;
    end
    if (state == recv_data && ui_rsp.app_rd_data_valid) begin
      rsp.mem_ready = 1'b1;
      if (cap.addr[3]) begin
        rsp.mem_rdata = ui_rsp.app_rd_data[127:64];
      end else begin
        rsp.mem_rdata = ui_rsp.app_rd_data[63:0];
      end
    end
  end

  a_cmd_data_exclusive : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    !(ui_req.app_en && ui_req.app_wdf_wren)
  ) else $error("mig_ui_seq: app_en and app_wdf_wren high together");

  a_cmd_stable : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    ui_req.app_en && !ui_rsp.app_rdy |=> $stable(ui_req)
  ) else $error("mig_ui_seq: UI command changed under back-pressure");

  a_wdf_stable : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    ui_req.app_wdf_wren && !ui_rsp.app_wdf_rdy |=> $stable(ui_req)
  ) else $error("mig_ui_seq: UI write data changed under back-pressure");

endmodule

// ==== rtl/port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter
  import dram_pkg::*;
(
  input  logic        app_ui_clk,
  input  logic        app_ui_rst,
  input  mem_in_type  port0_req,
  input  mem_in_type  port1_req,
  output mem_in_type  grant_req,
  input  mem_out_type seq_rsp,
  output logic        port0_done,
  output logic        port1_done,
  output data64_t     rsp_rdata
);

  logic p0_pend;
  logic p1_pend;
  logic lock;     // A grant is held
  logic owner;    // Port that holds the grant
  logic rr_prio;  // Port favoured on a tie
  logic pick;

  assign p0_pend = port0_req.mem_valid;
  assign p1_pend = port1_req.mem_valid;

  // Tie goes to rr_prio and otherwise to the only pending port
  assign pick = (p0_pend && p1_pend) ? rr_prio : p1_pend;

  // --------------------------------------------------
  // Grant lock and round-robin pointer
  // --------------------------------------------------
  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      lock    <= 1'b0;
      owner   <= 1'b0;
      rr_prio <= 1'b0;
    end else if (!lock) begin
      if (p0_pend || p1_pend) begin
        lock    <= 1'b1;
        owner   <= pick;
        rr_prio <= ~pick;  // Rotate past the winner
      end
    end else if (seq_rsp.mem_ready) begin
      lock <= 1'b0;
    end
  end

  always_comb begin
    grant_req           = owner ? port1_req : port0_req;
    grant_req.mem_valid = lock && (owner ? p1_pend : p0_pend);
  end

  assign port0_done = lock && !owner && seq_rsp.mem_ready;
  assign port1_done = lock && owner && seq_rsp.mem_ready;

  // Aligned with the registered mem_ready in mem_port
  always_ff @(posedge app_ui_clk) begin
    if (seq_rsp.mem_ready) begin
      rsp_rdata <= seq_rsp.mem_rdata;
    end
  end

  a_done_onehot : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    !(port0_done && port1_done)
  ) else $error("port_arbiter: done steered to both ports");

  a_grant_locked : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    lock && !seq_rsp.mem_ready |=> $stable(grant_req)
  ) else $error("port_arbiter: grant changed while locked");

  // Owner port keeps its request pending for the whole grant
  a_grant_valid : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    lock |-> grant_req.mem_valid
  ) else $error("port_arbiter: granted port dropped its request");

endmodule

// ==== rtl/mem_port.sv ====
`timescale 1ns/1ps

module mem_port
  import dram_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 27
) (
  input  logic        app_ui_clk,
  input  logic        app_ui_rst,
  input  mem_in_type  cpu_req,
  output mem_out_type cpu_rsp,
  output mem_in_type  pend_req,
  input  logic        done
);

  logic       in_range;
  logic       accept;
  logic       pend_valid;
  mem_in_type pend_hold;
  logic       ready_q;
  logic       error_q;

  // Address must lie below 2**MEM_ADDR_BITS
  assign in_range = (cpu_req.mem_addr >> MEM_ADDR_BITS) == '0;
  assign accept   = cpu_req.mem_valid && in_range;

  // --------------------------------------------------
  // Pending request
  // --------------------------------------------------
  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      pend_valid <= 1'b0;
    end else if (accept) begin
      pend_valid <= 1'b1;
    end else if (done) begin
      pend_valid <= 1'b0;  // Sequencer finished with it
    end
  end

  always_ff @(posedge app_ui_clk) begin
    if (accept) begin
      pend_hold <= cpu_req;
    end
  end

  assign pend_req = '{
    mem_valid: pend_valid,
    mem_addr:  pend_hold.mem_addr,
    mem_wdata: pend_hold.mem_wdata,
    mem_wstrb: pend_hold.mem_wstrb
  };

  // --------------------------------------------------
  // Response pulses
  // --------------------------------------------------
  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= done;
      error_q <= cpu_req.mem_valid && !in_range;  // Dropped, never forwarded
    end
  end

  // Read data joins from the arbiter at the top level
  assign cpu_rsp = '{mem_ready: ready_q, mem_error: error_q, mem_rdata: '0};

  a_no_strobe_while_pending : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    cpu_req.mem_valid |-> !pend_valid
  ) else $error("mem_port: request strobe while a request is pending");

  a_done_only_when_pending : assert property (
    @(posedge app_ui_clk) disable iff (app_ui_rst)
    done |-> pend_valid
  ) else $error("mem_port: done without a pending request");

endmodule

// ==== rtl/dram_pkg.sv ====
package dram_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  typedef logic [63:0]  data64_t;    // CPU data word
  typedef logic [127:0] data128_t;   // UI data beat
  typedef logic [7:0]   strb_t;      // CPU byte strobes
  typedef logic [15:0]  mask_t;      // UI byte mask where a set bit skips the byte
  typedef logic [31:0]  cpu_addr_t;  // CPU byte address
  typedef logic [26:0]  app_addr_t;  // UI address
  typedef logic [2:0]   ui_cmd_t;

  localparam ui_cmd_t UI_CMD_WR = 3'b000;
  localparam ui_cmd_t UI_CMD_RD = 3'b001;

  // --------------------------------------------------
  // CPU side
  // --------------------------------------------------
  typedef struct packed {
    logic      mem_valid;
    cpu_addr_t mem_addr;
    data64_t   mem_wdata;
    strb_t     mem_wstrb;  // Zero strobe is a read
  } mem_in_type;

  typedef struct packed {
    logic    mem_ready;
    logic    mem_error;
    data64_t mem_rdata;
  } mem_out_type;

  // --------------------------------------------------
  // Controller UI side
  // --------------------------------------------------
  typedef struct packed {
    app_addr_t app_addr;
    ui_cmd_t   app_cmd;
    logic      app_en;
    data128_t  app_wdf_data;
    logic      app_wdf_end;
    mask_t     app_wdf_mask;
    logic      app_wdf_wren;
  } ui_req_type;

  typedef struct packed {
    logic     app_rdy;
    logic     app_wdf_rdy;
    data128_t app_rd_data;
    logic     app_rd_data_valid;
    logic     app_rd_data_end;
  } ui_rsp_type;

endpackage
